// File: Makefile
# Verilator build and run for the UART peripheral
# make            build and run the testbench, fail if the log reports failure
# make lint       lint the RTL top level
# make clean      remove build products and the log

VERILATOR ?= verilator
FILELIST ?= vlog.f
TOP ?= uart_tb
RTL_TOP ?= uart_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= STATUS: FAIL
PASS_MSG ?= STATUS: PASS
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/rx_fifo.sv
// Receive FIFO between the serial receiver and the valid/ready output
// Writes that find it full are dropped and flagged on overrun
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module rx_fifo
	#(parameter int DEPTH = `UART_RX_FIFO_DEPTH)
	(input wire logic clk,
	input wire logic reset,
	input wire logic wr_valid,
	input wire uart_pkg::rx_entry_t wr_entry,
	output logic rd_valid,
	input wire logic rd_ready,
	output uart_pkg::rx_entry_t rd_entry,
	output logic overrun);

	import uart_pkg::*;

	localparam int PTR_W = DEPTH > 1 ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	rx_entry_t storage[DEPTH];
	logic [PTR_W-1:0] wr_ptr_ff;
	logic [PTR_W-1:0] rd_ptr_ff;
	logic [CNT_W-1:0] count_ff;
	logic full;
	logic do_read;
	logic do_write;

	assign full = count_ff == CNT_W'(DEPTH);
	assign rd_valid = count_ff != '0;
	assign do_read = rd_valid && rd_ready;

	// A read on the same edge frees a slot
	assign do_write = wr_valid && (!full || do_read);
	assign overrun = wr_valid && full && !do_read;

	// Oldest entry always on the output
	assign rd_entry = storage[rd_ptr_ff];

	always_ff @(posedge clk)
	begin
		if (do_write)
			storage[wr_ptr_ff] <= wr_entry;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr_ff <= '0;
			rd_ptr_ff <= '0;
			count_ff <= '0;
		end
		else
		begin
			// Pointers wrap at DEPTH, which need not be a power of two
			if (do_write)
			begin
				if (wr_ptr_ff == PTR_W'(DEPTH - 1))
					wr_ptr_ff <= '0;
				else
					wr_ptr_ff <= wr_ptr_ff + 1'b1;
			end

			if (do_read)
			begin
				if (rd_ptr_ff == PTR_W'(DEPTH - 1))
					rd_ptr_ff <= '0;
				else
					rd_ptr_ff <= rd_ptr_ff + 1'b1;
			end

			// Simultaneous read and write leave the count alone
			if (do_write && !do_read)
				count_ff <= count_ff + 1'b1;
			else if (do_read && !do_write)
				count_ff <= count_ff - 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		count_ff <= CNT_W'(DEPTH))
		else $error("FIFO count above DEPTH");

	// Held entry must not change under back-pressure
	assert property (@(posedge clk) disable iff (reset)
		rd_valid && !rd_ready |=> rd_valid && $stable(rd_entry))
		else $error("rd_entry changed while stalled");

endmodule

`default_nettype wire

// File: source/synchronizer.sv
// Two-flop synchronizer for an asynchronous input
// RESET_STATE sets the value both flops take in reset
`timescale 1ns/1ps
`default_nettype none

module synchronizer
	#(parameter logic RESET_STATE = 1'b0)
	(input wire logic clk,
	input wire logic reset,
	input wire logic data_i,
	output logic data_o);

	// First stage may go metastable
	logic sync0_ff;

	// Second stage settles before use
	logic sync1_ff;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Idle level so a quiet line is not a start bit
			sync0_ff <= RESET_STATE;
			sync1_ff <= RESET_STATE;
		end
		else
		begin
			sync0_ff <= data_i;
			sync1_ff <= sync0_ff;
		end
	end

	// Two clocks of delay
	assign data_o = sync1_ff;

endmodule

`default_nettype wire

// File: source/uart_consts.svh
// Default constants for the UART subsystem
// Included by the RTL and the testbench; modules take them as parameter defaults

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Clocks per oversample tick
// Small default keeps simulation short
`define UART_BAUD_DIVIDE 4

// Oversample ticks per serial bit
`define UART_OVERSAMPLE 8

// Default receive FIFO depth in entries
`define UART_RX_FIFO_DEPTH 4

`endif

// File: source/uart_pkg.sv
// Shared types for the UART receive and transmit paths
// Imported by every design module that moves characters or holds state
`default_nettype none

package uart_pkg;

	// One serial character
	typedef logic [7:0] uart_char_t;

	// Receive FIFO entry, character plus stop bit check
	typedef struct packed {
		uart_char_t data;
		logic frame_error;
	} rx_entry_t;

	// Receiver FSM
	typedef enum logic {
		STATE_WAIT_START,
		STATE_READ_CHARACTER
	} receive_state_t;

	// Transmitter FSM
	typedef enum logic {
		STATE_IDLE,
		STATE_SEND_FRAME
	} transmit_state_t;

endpackage

`default_nettype wire

// File: source/uart_receive.sv
// Oversampling serial receiver, one start bit, 8 data bits, one stop bit
// BAUD_DIVIDE is clock rate / (baud rate * 8); input must already be synchronized
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_receive
	#(parameter int BAUD_DIVIDE = `UART_BAUD_DIVIDE)
	(input wire logic clk,
	input wire logic reset,
	input wire logic rx_sync,
	output uart_pkg::uart_char_t char_data,
	output logic char_valid,
	output logic frame_error);

	import uart_pkg::*;

	// Ticks from start edge to centre of data bit 0, 1.5 bits
	localparam int START_TICKS = `UART_OVERSAMPLE + `UART_OVERSAMPLE / 2;
	localparam int SAMPLE_W = $clog2(START_TICKS + 1);
	localparam int DATA_BITS = $bits(uart_char_t);
	localparam int BIT_W = $clog2(DATA_BITS + 1);
	localparam int DIV_W = $clog2(BAUD_DIVIDE + 1);

	receive_state_t state_ff;
	receive_state_t state_nxt;
	logic [SAMPLE_W-1:0] sample_count_ff;
	logic [SAMPLE_W-1:0] sample_count_nxt;
	logic [BIT_W-1:0] bit_count_ff;
	logic [BIT_W-1:0] bit_count_nxt;
	logic [DIV_W-1:0] clock_divider;
	uart_char_t shift_register;
	logic sample_enable;
	logic do_shift;
	logic stop_sample;
	logic char_valid_ff;
	logic frame_error_ff;

	// One tick every BAUD_DIVIDE clocks
	assign sample_enable = clock_divider == '0;

	always_comb
	begin
		state_nxt = state_ff;
		sample_count_nxt = sample_count_ff;
		bit_count_nxt = bit_count_ff;
		do_shift = 1'b0;
		stop_sample = 1'b0;

		unique case (state_ff)
			STATE_WAIT_START:
			begin
				// Falling edge starts a frame
				if (!rx_sync)
				begin
					state_nxt = STATE_READ_CHARACTER;
					sample_count_nxt = SAMPLE_W'(START_TICKS);
				end
			end

			STATE_READ_CHARACTER:
			begin
				if (sample_count_ff == '0)
				begin
					// Next sample one bit later
					sample_count_nxt = SAMPLE_W'(`UART_OVERSAMPLE);
					if (bit_count_ff == BIT_W'(DATA_BITS))
					begin
						// Centre of the stop bit
						stop_sample = 1'b1;
						bit_count_nxt = '0;
						state_nxt = STATE_WAIT_START;
					end
					else
					begin
						do_shift = 1'b1;
						bit_count_nxt = bit_count_ff + 1'b1;
					end
				end
				else if (sample_enable)
					sample_count_nxt = sample_count_ff - 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_ff <= STATE_WAIT_START;
			sample_count_ff <= '0;
			bit_count_ff <= '0;
			clock_divider <= '0;
			char_valid_ff <= 1'b0;
			frame_error_ff <= 1'b0;
		end
		else
		begin
			state_ff <= state_nxt;
			sample_count_ff <= sample_count_nxt;
			bit_count_ff <= bit_count_nxt;

			// Strobe for one cycle, low stop bit is a framing error
			char_valid_ff <= stop_sample;
			if (stop_sample)
				frame_error_ff <= !rx_sync;

			// Free running tick divider
			if (clock_divider == '0)
				clock_divider <= DIV_W'(BAUD_DIVIDE - 1);
			else
				clock_divider <= clock_divider - 1'b1;
		end
	end

	// LSB arrives first, shift in from the top
	always_ff @(posedge clk)
	begin
		if (do_shift)
			shift_register <= {rx_sync, shift_register[DATA_BITS-1:1]};
	end

	// Data holds until the next start edge, at least half a bit away
	assign char_data = shift_register;
	assign char_valid = char_valid_ff;
	assign frame_error = frame_error_ff;

	// Stop sample and return to wait-start keep strobes apart
	assert property (@(posedge clk) disable iff (reset)
		char_valid |=> !char_valid)
		else $error("char_valid high in two consecutive cycles");

endmodule

`default_nettype wire

// File: source/uart_top.sv
// UART peripheral top, receive path of synchronizer, receiver and FIFO
// next to a single-stage transmitter; all external signals are plain ports
`timescale 1ns/1ps
`default_nettype none

module uart_top
	(input wire logic clk,
	input wire logic reset,
	input wire logic uart_rx,
	output logic uart_tx,
	input wire logic tx_valid,
	output logic tx_ready,
	input wire uart_pkg::uart_char_t tx_data,
	output logic rx_valid,
	input wire logic rx_ready,
	output uart_pkg::uart_char_t rx_data,
	output logic rx_frame_error,
	output logic rx_overrun);

	import uart_pkg::*;

	logic rx_sync;
	uart_char_t char_data;
	logic char_valid;
	logic frame_error;
	rx_entry_t wr_entry;
	rx_entry_t rd_entry;

	// Line idles high
	synchronizer #(.RESET_STATE(1'b1)) rx_synchronizer(
		.clk(clk),
		.reset(reset),
		.data_i(uart_rx),
		.data_o(rx_sync));

	uart_receive receive_i(
		.clk(clk),
		.reset(reset),
		.rx_sync(rx_sync),
		.char_data(char_data),
		.char_valid(char_valid),
		.frame_error(frame_error));

	// Pack receiver outputs into a FIFO entry
	assign wr_entry.data = char_data;
	assign wr_entry.frame_error = frame_error;

	rx_fifo fifo_i(
		.clk(clk),
		.reset(reset),
		.wr_valid(char_valid),
		.wr_entry(wr_entry),
		.rd_valid(rx_valid),
		.rd_ready(rx_ready),
		.rd_entry(rd_entry),
		.overrun(rx_overrun));

	assign rx_data = rd_entry.data;
	assign rx_frame_error = rd_entry.frame_error;

	uart_transmit transmit_i(
		.clk(clk),
		.reset(reset),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx_data(tx_data),
		.uart_tx(uart_tx));

endmodule

`default_nettype wire

// File: source/uart_transmit.sv
// Serial transmitter, takes one character on valid/ready and sends an 8N1 frame
// Each bit lasts 8 * BAUD_DIVIDE clocks
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_transmit
	#(parameter int BAUD_DIVIDE = `UART_BAUD_DIVIDE)
	(input wire logic clk,
	input wire logic reset,
	input wire logic tx_valid,
	output logic tx_ready,
	input wire uart_pkg::uart_char_t tx_data,
	output logic uart_tx);

	import uart_pkg::*;

	// Start, data, stop
	localparam int FRAME_BITS = $bits(uart_char_t) + 2;
	localparam int DIV_W = $clog2(BAUD_DIVIDE + 1);
	localparam int OS_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W = $clog2(FRAME_BITS);

	transmit_state_t state_ff;
	logic [FRAME_BITS-1:0] frame_ff;
	logic [DIV_W-1:0] tick_count_ff;
	logic [OS_W-1:0] os_count_ff;
	logic [BIT_W-1:0] bit_count_ff;
	logic accept;
	logic tick_end;
	logic bit_end;

	assign tx_ready = state_ff == STATE_IDLE;
	assign accept = tx_valid && tx_ready;

	// Last clock of a tick, then last tick of a bit
	assign tick_end = tick_count_ff == DIV_W'(BAUD_DIVIDE - 1);
	assign bit_end = tick_end && os_count_ff == OS_W'(`UART_OVERSAMPLE - 1);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_ff <= STATE_IDLE;
			// All ones keeps the line idle high
			frame_ff <= '1;
			tick_count_ff <= '0;
			os_count_ff <= '0;
			bit_count_ff <= '0;
		end
		else if (state_ff == STATE_IDLE)
		begin
			if (accept)
			begin
				// Start bit goes out on the next cycle
				state_ff <= STATE_SEND_FRAME;
				frame_ff <= {1'b1, tx_data, 1'b0};
				tick_count_ff <= '0;
				os_count_ff <= '0;
				bit_count_ff <= '0;
			end
		end
		else
		begin
			if (tick_end)
			begin
				tick_count_ff <= '0;
				os_count_ff <= os_count_ff + 1'b1;
			end
			else
				tick_count_ff <= tick_count_ff + 1'b1;

			if (bit_end)
			begin
				// Fill with ones so the line rests high after the stop bit
				frame_ff <= {1'b1, frame_ff[FRAME_BITS-1:1]};
				bit_count_ff <= bit_count_ff + 1'b1;
				if (bit_count_ff == BIT_W'(FRAME_BITS - 1))
					state_ff <= STATE_IDLE;
			end
		end
	end

	// Straight from a flop, no glitches on the pin
	assign uart_tx = frame_ff[0];

	assert property (@(posedge clk) disable iff (reset)
		state_ff == STATE_IDLE |-> uart_tx)
		else $error("uart_tx low while idle");

endmodule

`default_nettype wire

// File: verification/uart_tb.sv
// Self-checking testbench for the UART peripheral top level
// Runs reset, transmit timing, loopback, framing error and overrun tests checked by assertions
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_tb;

	import uart_pkg::*;

	localparam int BIT_CYCLES = `UART_OVERSAMPLE * `UART_BAUD_DIVIDE;
	localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
	localparam int LOOPBACK_BYTES = 16;
	localparam int DEPTH = `UART_RX_FIFO_DEPTH;
	// Framing test counts as four frames because of its long idle gap
	localparam int TOTAL_FRAMES = 1 + LOOPBACK_BYTES + 4 + DEPTH + 2;
	localparam int CYCLE_LIMIT = (TOTAL_FRAMES + 4) * FRAME_CYCLES;

	logic clk;
	logic reset = 1'b1;
	logic uart_rx;
	logic uart_tx;
	logic tx_valid = 1'b0;
	logic tx_ready;
	uart_char_t tx_data = '0;
	logic rx_valid;
	logic rx_ready = 1'b1;
	uart_char_t rx_data;
	logic rx_frame_error;
	logic rx_overrun;

	// Line source select between transmitter output and frame generator
	logic loopback = 1'b0;
	logic gen_line = 1'b1;

	// Check windows opened by the stimulus
	logic reset_check = 1'b0;
	logic tx_bit_check = 1'b0;
	logic tx_bit_expected = 1'b1;
	logic tx_ready_check = 1'b0;
	logic tx_ready_expected = 1'b1;
	logic drain_check = 1'b0;

	// Reference queue of entries still due on the receive port
	rx_entry_t expected_q[$];
	int expected_count = 0;
	uart_char_t expected_data = '0;
	logic expected_frame_error = 1'b0;
	int overrun_count = 0;

	logic [31:0] lfsr_state = 32'haf50a9ca;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int watchdog_cycles;

	assign uart_rx = loopback ? uart_tx : gen_line;

	uart_top dut_i(
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx_data(tx_data),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.rx_data(rx_data),
		.rx_frame_error(rx_frame_error),
		.rx_overrun(rx_overrun));

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	// New bit enters at the bottom
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// One LFSR step per data bit
	task automatic random_byte(output uart_char_t value);
		for (int i = 0; i < 8; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value[i] = lfsr_state[0];
		end
	endtask

	// Head of the queue mirrored into plain variables for the assertions
	function automatic void refresh_expected();
		expected_count = expected_q.size();
		if (expected_q.size() != 0)
		begin
			expected_data = expected_q[0].data;
			expected_frame_error = expected_q[0].frame_error;
		end
	endfunction

	function automatic void expect_entry(input uart_char_t value, input logic frame_error);
		rx_entry_t entry;
		entry.data = value;
		entry.frame_error = frame_error;
		expected_q.push_back(entry);
		refresh_expected();
	endfunction

	// Hold tx_valid until the transmitter takes the byte
	task automatic send_byte(input uart_char_t value);
		@(posedge clk);
		tx_valid <= 1'b1;
		tx_data <= value;
		do
			@(negedge clk);
		while (!tx_ready);
		@(posedge clk);
		tx_valid <= 1'b0;
	endtask

	// Start bit, data LSB first, then the given stop bit
	task automatic send_serial_frame(input uart_char_t value, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, value, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			gen_line <= frame[i];
			repeat (BIT_CYCLES - 1) @(posedge clk);
		end
		@(posedge clk);
		gen_line <= 1'b1;
	endtask

	task automatic wait_for_drain();
		do
			@(negedge clk);
		while (expected_count != 0);
	endtask

	task automatic report_test(input string name, input int errors_before);
		// Action blocks of the last checked edge run before this negedge
		@(negedge clk);
		tests_run++;
		if (error_count == errors_before)
			$display("Test %s: passed", name);
		else
		begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	// Entry leaves the FIFO on this edge
	always @(posedge clk)
	begin
		if (!reset && rx_valid && rx_ready && expected_q.size() != 0)
		begin
			void'(expected_q.pop_front());
			refresh_expected();
		end
		if (!reset && rx_overrun)
			overrun_count <= overrun_count + 1;
	end

	assert property (@(posedge clk) disable iff (reset)
		reset_check |-> tx_ready && uart_tx && !rx_valid && !rx_overrun)
	else
	begin
		error_count++;
		$display("FAILED reset state: tx_ready=%h uart_tx=%h rx_valid=%h rx_overrun=%h",
			$sampled(tx_ready), $sampled(uart_tx), $sampled(rx_valid), $sampled(rx_overrun));
	end

	assert property (@(posedge clk) disable iff (reset)
		tx_bit_check |-> uart_tx == tx_bit_expected)
	else
	begin
		error_count++;
		$display("FAILED uart_tx: got %h expected %h", $sampled(uart_tx),
			$sampled(tx_bit_expected));
	end

	assert property (@(posedge clk) disable iff (reset)
		tx_ready_check |-> tx_ready == tx_ready_expected)
	else
	begin
		error_count++;
		$display("FAILED tx_ready: got %h expected %h", $sampled(tx_ready),
			$sampled(tx_ready_expected));
	end

	assert property (@(posedge clk) disable iff (reset)
		rx_valid && rx_ready |-> expected_count != 0)
	else
	begin
		error_count++;
		$display("Received a character that was not expected");
	end

	assert property (@(posedge clk) disable iff (reset)
		rx_valid && rx_ready && expected_count != 0 |-> rx_data == expected_data)
	else
	begin
		error_count++;
		$display("FAILED rx_data: got %h expected %h", $sampled(rx_data),
			$sampled(expected_data));
	end

	assert property (@(posedge clk) disable iff (reset)
		rx_valid && rx_ready && expected_count != 0 |-> rx_frame_error == expected_frame_error)
	else
	begin
		error_count++;
		$display("FAILED rx_frame_error: got %h expected %h", $sampled(rx_frame_error),
			$sampled(expected_frame_error));
	end

	// Stalled entry stays on the port unchanged
	assert property (@(posedge clk) disable iff (reset)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_data) && $stable(rx_frame_error))
	else
	begin
		error_count++;
		$display("Held receive entry dropped or changed before it was read");
	end

	assert property (@(posedge clk) disable iff (reset)
		drain_check |-> overrun_count == 2 && !rx_valid)
	else
	begin
		error_count++;
		$display("FAILED overrun_count: got %h expected %h, rx_valid: got %h expected 0",
			$sampled(overrun_count), 2, $sampled(rx_valid));
	end

	initial
	begin
		for (watchdog_cycles = 0; watchdog_cycles < CYCLE_LIMIT; watchdog_cycles++)
			@(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		uart_char_t value;
		int errors_before;

		repeat (5) @(posedge clk);
		reset <= 1'b0;

		errors_before = error_count;
		@(posedge clk);
		reset_check <= 1'b1;
		@(posedge clk);
		reset_check <= 1'b0;
		report_test("reset state", errors_before);

		// Cycle 0 is the first cycle with uart_tx low
		// Each bit is checked BIT_CYCLES/2 cycles into its period
		errors_before = error_count;
		random_byte(value);
		send_byte(value);
		do
			@(negedge clk);
		while (uart_tx);
		for (int i = 0; i < 10; i++)
		begin
			repeat (i == 0 ? BIT_CYCLES / 2 : BIT_CYCLES - 1) @(posedge clk);
			tx_bit_check <= 1'b1;
			// Start bit low, data LSB first, stop bit high
			if (i == 0)
				tx_bit_expected <= 1'b0;
			else if (i == 9)
				tx_bit_expected <= 1'b1;
			else
				tx_bit_expected <= value[i - 1];
			@(posedge clk);
			tx_bit_check <= 1'b0;
		end
		// tx_ready low in the last stop cycle and high 10 bit periods after the start
		repeat (BIT_CYCLES / 2 - 2) @(posedge clk);
		tx_ready_check <= 1'b1;
		tx_ready_expected <= 1'b0;
		@(posedge clk);
		tx_ready_expected <= 1'b1;
		@(posedge clk);
		tx_ready_check <= 1'b0;
		report_test("transmit timing", errors_before);

		errors_before = error_count;
		@(posedge clk);
		loopback <= 1'b1;
		for (int i = 0; i < LOOPBACK_BYTES; i++)
		begin
			random_byte(value);
			expect_entry(value, 1'b0);
			send_byte(value);
		end
		wait_for_drain();
		report_test("loopback data", errors_before);

		errors_before = error_count;
		@(posedge clk);
		loopback <= 1'b0;
		random_byte(value);
		expect_entry(value, 1'b1);
		// Receiver rearms at the stop sample, so the rest of the low stop bit
		// starts a frame that reads the idle line as all ones
		expect_entry(8'hff, 1'b0);
		send_serial_frame(value, 1'b0);
		repeat (12 * BIT_CYCLES) @(posedge clk);
		random_byte(value);
		expect_entry(value, 1'b0);
		send_serial_frame(value, 1'b1);
		wait_for_drain();
		report_test("framing error", errors_before);

		// Only the first DEPTH characters fit and the rest are dropped
		errors_before = error_count;
		@(posedge clk);
		rx_ready <= 1'b0;
		loopback <= 1'b1;
		for (int i = 0; i < DEPTH + 2; i++)
		begin
			random_byte(value);
			if (i < DEPTH)
				expect_entry(value, 1'b0);
			send_byte(value);
		end
		do
			@(negedge clk);
		while (overrun_count < 2);
		@(posedge clk);
		rx_ready <= 1'b1;
		wait_for_drain();
		@(posedge clk);
		drain_check <= 1'b1;
		@(posedge clk);
		drain_check <= 1'b0;
		report_test("back-pressure and overrun", errors_before);

		$display("Tests run %0d, passed %0d, failed %0d, assertion errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/uart_pkg.sv
source/synchronizer.sv
source/uart_receive.sv
source/rx_fifo.sv
source/uart_transmit.sv
source/uart_top.sv
verification/uart_tb.sv
